// File: common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [7:0]  byte_t;                // One data byte
    typedef logic [15:0] addr_t;                // Bus address

    // Microcode states
    typedef enum logic [3:0] {
        RESET0,                                 // Drive FFFC
        RESET1,                                 // Drive FFFD, low vector byte arrives
        DECODE,                                 // Opcode on din, write previous result
        FETCH,                                  // Fetch next opcode, ALU runs
        REG,                                    // Register-only ALU cycle
        ZP0,                                    // Zero page operand address
        ABS0,                                   // Absolute, low byte arrives
        ABS1,                                   // Absolute, high byte arrives
        JMP0,                                   // JMP low byte arrives
        JMP1                                    // JMP high byte, jump target on bus
    } state_t;

    typedef enum logic [2:0] {
        OP_OR,
        OP_AND,
        OP_EOR,
        OP_ADD,                                 // A + B + ci
        OP_SUB,                                 // A + ~B + ci
        OP_PASS_B                               // Loads
    } alu_op_t;

    typedef enum logic [1:0] {
        SEL_A = 2'd0,
        SEL_X = 2'd1,
        SEL_Y = 2'd2                            // Code 3 never used
    } reg_sel_t;

    typedef enum logic [2:0] {
        SRC_PC,
        SRC_VEC_LO,
        SRC_VEC_HI,
        SRC_ZP_DI,                              // {00, din}
        SRC_ABS_DI,                             // {din, held low byte}
        SRC_HOLD                                // Previous cycle's address
    } addr_src_t;

    typedef enum logic [1:0] {
        AI_ZERO,
        AI_REG
    } ai_src_t;

    typedef enum logic [1:0] {
        CI_ZERO,
        CI_ONE,
        CI_FLAG                                 // Carry flag, for ADC/SBC
    } ci_src_t;

    localparam addr_t RESET_VECTOR = 16'hfffc;
    localparam byte_t ZERO_PAGE    = 8'h00;

endpackage

`default_nettype wire

// File: hdl/cpu_pc_addr.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_pc_addr (
    input  logic                clk,
    input  logic                reset,
    input  logic                rdy,
    input  cpu_pkg::addr_src_t  addr_src,
    input  logic                pc_inc,
    input  cpu_pkg::byte_t      din,
    output cpu_pkg::addr_t      addr
);
    import cpu_pkg::*;

    addr_t pc;
    addr_t addr_hold;                           // Last cycle's bus address
    byte_t lo_byte;                             // Low operand byte from last cycle

    always_comb begin
        case (addr_src)
            SRC_VEC_LO: addr = RESET_VECTOR;
            SRC_VEC_HI: addr = RESET_VECTOR + 16'd1;
            SRC_ZP_DI:  addr = {ZERO_PAGE, din};
            SRC_ABS_DI: addr = {din, lo_byte};  // Absolute, JMP target, reset vector
            SRC_HOLD:   addr = addr_hold;
            default:    addr = pc;
        endcase
    end

    // Incrementing from the bus address also loads jump targets
    always_ff @(posedge clk) begin
        if (reset)
            pc <= RESET_VECTOR;
        else if (pc_inc)
            pc <= addr + 16'd1;
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            addr_hold <= addr;
            lo_byte <= din;                     // Used next cycle by ABS1 and JMP1
        end
    end

    a_addr_stall: assert property (@(posedge clk) disable iff (reset)
        !rdy |=> $stable(addr));

endmodule

`default_nettype wire

// File: hdl/cpu_alu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_alu (
    input  logic                clk,
    input  logic                reset,
    input  logic                rdy,
    input  cpu_pkg::byte_t      data_in,
    input  cpu_pkg::byte_t      reg_data,
    input  cpu_pkg::alu_op_t    alu_op,
    input  cpu_pkg::ai_src_t    ai_src,
    input  cpu_pkg::ci_src_t    ci_src,
    input  logic                alu_load,
    input  logic                carry_update,
    input  logic                set_carry,
    input  logic                clr_carry,
    output cpu_pkg::byte_t      din,
    output cpu_pkg::byte_t      alu_out,
    output logic                carry_out
);
    import cpu_pkg::*;

    logic       rdy_q;                          // Previous cycle advanced
    byte_t      din_hold;
    byte_t      ai, bi, bx, result;
    logic       ci, b_zero, co, carry;
    logic [8:0] sum;

    // Data in is valid only in the first cycle after a ready cycle
    always_ff @(posedge clk) begin
        if (reset)
            rdy_q <= 1'b1;
        else
            rdy_q <= rdy;
    end

    always_ff @(posedge clk) begin
        if (rdy_q)
            din_hold <= data_in;
    end

    assign din = rdy_q ? data_in : din_hold;

    always_comb begin
        // Register ops (transfers, INC, DEC) run without the flag, B is zero
        b_zero = ((alu_op == OP_ADD) && (ci_src != CI_FLAG)) ||
                 ((alu_op == OP_SUB) && (ci_src == CI_ZERO));
        ai = (ai_src == AI_REG) ? reg_data : 8'h00;
        bi = b_zero ? 8'h00 : din;
        bx = (alu_op == OP_SUB) ? ~bi : bi;     // Subtract as add of inverse
        case (ci_src)
            CI_ONE:  ci = 1'b1;
            CI_FLAG: ci = carry;
            default: ci = 1'b0;
        endcase
        sum = {1'b0, ai} + {1'b0, bx} + {8'h00, ci};
        co = 1'b0;
        case (alu_op)
            OP_OR:          result = ai | bi;
            OP_AND:         result = ai & bi;
            OP_EOR:         result = ai ^ bi;
            OP_ADD, OP_SUB: begin
                result = sum[7:0];
                co = sum[8];                    // SUB carry is not-borrow
            end
            default:        result = bi;        // Loads
        endcase
    end

    always_ff @(posedge clk) begin
        if (alu_load) begin
            alu_out <= result;
            carry_out <= co;
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            carry <= 1'b0;
        else if (carry_update)
            carry <= carry_out;
        else if (set_carry)
            carry <= 1'b1;
        else if (clr_carry)
            carry <= 1'b0;
    end

endmodule

`default_nettype wire

// File: hdl/cpu_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_regfile (
    input  logic                clk,
    input  logic                rdy,
    input  cpu_pkg::reg_sel_t   reg_sel,
    input  logic                reg_we,
    input  cpu_pkg::byte_t      alu_out,
    output cpu_pkg::byte_t      reg_data
);
    import cpu_pkg::*;

    byte_t regs [0:2];                          // A, X, Y

    assign reg_data = regs[reg_sel];            // Shared by ALU input and store data

    always_ff @(posedge clk) begin
        if (reg_we && rdy)
            regs[reg_sel] <= alu_out;
    end

    a_sel_valid: assert property (@(posedge clk)
        reg_we |-> reg_sel inside {SEL_A, SEL_X, SEL_Y});

endmodule

`default_nettype wire

// File: hdl/cpu_control.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_control (
    input  logic                clk,
    input  logic                reset,
    input  logic                rdy,
    input  cpu_pkg::byte_t      din,
    input  logic                carry_out,
    output cpu_pkg::addr_src_t  addr_src,
    output logic                pc_inc,
    output cpu_pkg::alu_op_t    alu_op,
    output cpu_pkg::ai_src_t    ai_src,
    output cpu_pkg::ci_src_t    ci_src,
    output logic                alu_load,
    output logic                carry_update,
    output logic                set_carry,
    output logic                clr_carry,
    output cpu_pkg::reg_sel_t   reg_sel,
    output logic                reg_we,
    output logic                we
);
    import cpu_pkg::*;

    state_t   state, dec_state;
    alu_op_t  op, dec_op;                       // Latched / decoded ALU operation
    reg_sel_t src_reg, dst_reg, dec_src, dec_dst;
    logic     store, load_only, compare, adc_sbc, inc, load_reg, clc, sec;
    logic     dec_store, dec_load_only, dec_compare, dec_adc_sbc, dec_inc;
    logic     dec_load_reg, dec_clc, dec_sec, dec_mem;

    // Opcode decode, din holds the opcode in DECODE
    always_comb begin
        dec_state = REG;                        // Unknown opcodes run as NOP
        dec_op = OP_PASS_B;
        dec_src = SEL_A;
        dec_dst = SEL_A;
        {dec_store, dec_load_only, dec_compare, dec_adc_sbc} = '0;
        {dec_inc, dec_load_reg, dec_clc, dec_sec, dec_mem} = '0;
        case (din)
            8'h09, 8'h05, 8'h0d: {dec_op, dec_load_reg, dec_mem} = {OP_OR, 2'b11};
            8'h29, 8'h25, 8'h2d: {dec_op, dec_load_reg, dec_mem} = {OP_AND, 2'b11};
            8'h49, 8'h45, 8'h4d: {dec_op, dec_load_reg, dec_mem} = {OP_EOR, 2'b11};
            8'h69, 8'h65, 8'h6d: {dec_op, dec_adc_sbc, dec_load_reg, dec_mem} = {OP_ADD, 3'b111};
            8'he9, 8'he5, 8'hed: {dec_op, dec_adc_sbc, dec_load_reg, dec_mem} = {OP_SUB, 3'b111};
            8'hc9, 8'hc5, 8'hcd: {dec_op, dec_compare, dec_mem} = {OP_SUB, 2'b11};  // No reg write
            8'ha9, 8'ha5, 8'had: {dec_load_only, dec_load_reg, dec_mem} = 3'b111;
            8'ha2, 8'ha6, 8'hae: begin          // LDX
                {dec_load_only, dec_load_reg, dec_mem} = 3'b111;
                dec_dst = SEL_X;
            end
            8'ha0, 8'ha4, 8'hac: begin          // LDY
                {dec_load_only, dec_load_reg, dec_mem} = 3'b111;
                dec_dst = SEL_Y;
            end
            8'h85, 8'h8d: {dec_store, dec_mem} = 2'b11;
            8'h86, 8'h8e: {dec_src, dec_store, dec_mem} = {SEL_X, 2'b11};
            8'h84, 8'h8c: {dec_src, dec_store, dec_mem} = {SEL_Y, 2'b11};
            8'haa: {dec_op, dec_dst, dec_load_reg} = {OP_ADD, SEL_X, 1'b1};         // TAX
            8'h8a: {dec_op, dec_src, dec_load_reg} = {OP_ADD, SEL_X, 1'b1};         // TXA
            8'ha8: {dec_op, dec_dst, dec_load_reg} = {OP_ADD, SEL_Y, 1'b1};         // TAY
            8'h98: {dec_op, dec_src, dec_load_reg} = {OP_ADD, SEL_Y, 1'b1};         // TYA
            8'he8: {dec_op, dec_src, dec_dst, dec_inc, dec_load_reg} = {OP_ADD, SEL_X, SEL_X, 2'b11};
            8'hc8: {dec_op, dec_src, dec_dst, dec_inc, dec_load_reg} = {OP_ADD, SEL_Y, SEL_Y, 2'b11};
            8'hca: {dec_op, dec_src, dec_dst, dec_load_reg} = {OP_SUB, SEL_X, SEL_X, 1'b1};
            8'h88: {dec_op, dec_src, dec_dst, dec_load_reg} = {OP_SUB, SEL_Y, SEL_Y, 1'b1};
            8'h18: dec_clc = 1'b1;
            8'h38: dec_sec = 1'b1;
            8'h4c: dec_state = JMP0;
            default: ;
        endcase
        if (dec_mem) begin                      // Mode from the low nibble
            case (din[3:0])
                4'h0, 4'h2, 4'h9: dec_state = FETCH;
                4'h4, 4'h5, 4'h6: dec_state = ZP0;
                default:          dec_state = ABS0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= RESET0;
            {store, load_only, compare, adc_sbc, inc, load_reg, clc, sec} <= '0;
            op <= OP_PASS_B;
            src_reg <= SEL_A;
            dst_reg <= SEL_A;
        end else if (rdy) begin
            case (state)
                RESET0:  state <= RESET1;
                RESET1:  state <= JMP1;         // Vector high byte takes the JMP1 path
                DECODE:  state <= dec_state;
                ZP0:     state <= FETCH;
                ABS0:    state <= ABS1;
                ABS1:    state <= FETCH;
                JMP0:    state <= JMP1;
                default: state <= DECODE;       // FETCH, REG, JMP1
            endcase
            if (state == DECODE) begin          // Previous flags used this cycle, then replaced
                {store, load_only, compare, adc_sbc} <= {dec_store, dec_load_only,
                                                         dec_compare, dec_adc_sbc};
                {inc, load_reg, clc, sec} <= {dec_inc, dec_load_reg, dec_clc, dec_sec};
                op <= dec_op;
                src_reg <= dec_src;
                dst_reg <= dec_dst;
            end
        end
    end

    always_comb begin
        case (state)
            RESET0:     addr_src = SRC_VEC_LO;
            RESET1:     addr_src = SRC_VEC_HI;
            ZP0:        addr_src = SRC_ZP_DI;
            ABS1, JMP1: addr_src = SRC_ABS_DI;
            REG:        addr_src = SRC_HOLD;    // Re-read next opcode
            default:    addr_src = SRC_PC;
        endcase
    end

    assign pc_inc = rdy && (state inside {DECODE, FETCH, ABS0, JMP1});
    assign alu_op = op;
    assign ai_src = load_only ? AI_ZERO : AI_REG;
    assign ci_src = adc_sbc ? CI_FLAG : ((compare || inc) ? CI_ONE : CI_ZERO);
    assign alu_load = rdy && (state == FETCH || state == REG);
    assign carry_update = rdy && state == DECODE && (adc_sbc || compare);
    assign set_carry = rdy && state == DECODE && sec;
    assign clr_carry = rdy && state == DECODE && clc;
    assign reg_sel = (state == DECODE) ? dst_reg : src_reg;
    assign reg_we = rdy && state == DECODE && load_reg;
    assign we = rdy && store && (state == ZP0 || state == ABS1);

    a_we_state: assert property (@(posedge clk) disable iff (reset)
        we |-> addr_src inside {SRC_ZP_DI, SRC_ABS_DI});  // Store address straight from din
    a_we_single: assert property (@(posedge clk) disable iff (reset)
        we |=> !we);                                      // One write per store
    a_state_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(state));
    a_carry_known: assert property (@(posedge clk) disable iff (reset)
        carry_update |-> !$isunknown(carry_out));  // ALU result from FETCH must be valid

endmodule

`default_nettype wire

// File: hdl/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
    input  logic            clk,
    input  logic            reset,
    input  logic            rdy,
    input  cpu_pkg::byte_t  data_in,
    output cpu_pkg::addr_t  addr,
    output cpu_pkg::byte_t  data_out,
    output logic            we
);
    import cpu_pkg::*;

    addr_src_t addr_src;
    logic      pc_inc;
    alu_op_t   alu_op;
    ai_src_t   ai_src;
    ci_src_t   ci_src;
    logic      alu_load, carry_update, set_carry, clr_carry;
    reg_sel_t  reg_sel;
    logic      reg_we;
    logic      carry_out;
    byte_t     din;                             // Stall-safe data in
    byte_t     alu_out;
    byte_t     reg_data;

    assign data_out = reg_data;                 // Stores always write the selected register

    cpu_control cpu_control_i (
        .clk(clk), .reset(reset), .rdy(rdy), .din(din), .carry_out(carry_out),
        .addr_src(addr_src), .pc_inc(pc_inc), .alu_op(alu_op), .ai_src(ai_src),
        .ci_src(ci_src), .alu_load(alu_load), .carry_update(carry_update),
        .set_carry(set_carry), .clr_carry(clr_carry), .reg_sel(reg_sel),
        .reg_we(reg_we), .we(we)
    );

    cpu_pc_addr cpu_pc_addr_i (
        .clk(clk), .reset(reset), .rdy(rdy), .addr_src(addr_src), .pc_inc(pc_inc),
        .din(din), .addr(addr)
    );

    cpu_alu cpu_alu_i (
        .clk(clk), .reset(reset), .rdy(rdy), .data_in(data_in), .reg_data(reg_data),
        .alu_op(alu_op), .ai_src(ai_src), .ci_src(ci_src), .alu_load(alu_load),
        .carry_update(carry_update), .set_carry(set_carry), .clr_carry(clr_carry),
        .din(din), .alu_out(alu_out), .carry_out(carry_out)
    );

    cpu_regfile cpu_regfile_i (
        .clk(clk), .rdy(rdy), .reg_sel(reg_sel), .reg_we(reg_we), .alu_out(alu_out),
        .reg_data(reg_data)
    );

endmodule

`default_nettype wire

// File: tests/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;
    import cpu_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 8;
    localparam int WAIT_LIMIT = 300;                // Cycles allowed per program
    localparam int TEST_COUNT = 6;
    localparam int WATCHDOG_CYCLES = TEST_COUNT * (WAIT_LIMIT + RESET_CYCLES + 4) + 100;

    logic  clk = 1'b0;
    logic  reset, rdy, we;
    byte_t data_in, data_out;
    addr_t addr;

    byte_t mem [0:65535];                           // 64 KB program and data memory
    addr_t wr_addr[$], exp_addr[$];
    byte_t wr_data[$], exp_data[$];
    int    sentinel_count, sentinel_base, errors;
    addr_t load_ptr;                                // Next program byte
    byte_t ls_val [0:5];                            // Load/store values, reused for the stall run

    cpu_core cpu_core_i (.clk(clk), .reset(reset), .rdy(rdy), .data_in(data_in),
        .addr(addr), .data_out(data_out), .we(we));

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Memory answers one cycle late, logs every store
    initial begin : memory_model
        addr_t bus_addr;
        logic  bus_we;
        byte_t bus_data;
        data_in = 8'h00;
        sentinel_count = 0;
        forever begin
            @(negedge clk);                         // Bus is settled mid-cycle
            bus_addr = addr;
            bus_we = we;
            bus_data = data_out;
            @(posedge clk);
            if (bus_we && bus_addr == 16'h00ff)
                sentinel_count++;                   // End-of-program marker
            else if (bus_we) begin
                wr_addr.push_back(bus_addr);
                wr_data.push_back(bus_data);
            end
            if (bus_we)
                mem[bus_addr] = bus_data;           // Store lands on this edge
            #1;
            data_in = mem[bus_addr];
        end
    end

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t: %s address %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_byte(input byte_t got, input byte_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t: %s data %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic begin_program(input addr_t org);
        for (int i = 0; i < 65536; i++)
            mem[i] = byte_t'(i ^ (i >> 8));         // Filler, never executed
        mem[16'hfffc] = org[7:0];                   // Reset vector
        mem[16'hfffd] = org[15:8];
        load_ptr = org;
    endtask

    task automatic put(input int b);
        mem[load_ptr] = byte_t'(b);
        load_ptr++;
    endtask

    task automatic put_op_byte(input int op, input int operand);
        put(op);
        put(operand);
    endtask

    task automatic put_op_word(input int op, input int operand);
        put(op);
        put(operand & 8'hff);                       // Little endian
        put(operand >> 8);
    endtask

    task automatic end_program;
        int here;
        put_op_byte(8'h85, 8'hff);                  // STA $FF marks the end
        here = load_ptr;
        put_op_word(8'h4c, here);                   // Park in a JMP to itself
    endtask

    // LDA #a, then op with immediate/zp/abs operand, then STA zp
    task automatic lda_op_sta(input int a, input int op, input int operand, input int dst);
        put_op_byte(8'ha9, a);
        if (op[3:0] == 4'hd)
            put_op_word(op, operand);
        else
            put_op_byte(op, operand);
        put_op_byte(8'h85, dst);
    endtask

    task automatic expect_write(input int a, input int d);
        exp_addr.push_back(addr_t'(a));
        exp_data.push_back(byte_t'(d));             // Wraps to 8 bits
    endtask

    task automatic release_reset;
        @(posedge clk);
        #1 reset = 1'b1;
        rdy = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
        wr_addr.delete();
        wr_data.delete();
        sentinel_base = sentinel_count;
    endtask

    task automatic wait_sentinel(input bit stalls);
        int cycles;
        cycles = 0;
        while (sentinel_count == sentinel_base && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #1 rdy = stalls ? (($urandom % 4) != 0) : 1'b1;   // About one stall in four
            cycles++;
        end
        rdy = 1'b1;
        if (sentinel_count == sentinel_base) begin
            errors++;
            $display("Program did not reach its end store within %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic compare_writes(input string name);
        if (wr_addr.size() != exp_addr.size()) begin
            errors++;
            $display("[FAIL] t=%0t: %s made %0d writes, expected %0d", $time, name,
                wr_addr.size(), exp_addr.size());
        end
        for (int i = 0; i < wr_addr.size() && i < exp_addr.size(); i++) begin
            check_addr(wr_addr[i], exp_addr[i], $sformatf("%s write %0d", name, i));
            check_byte(wr_data[i], exp_data[i], $sformatf("%s write %0d", name, i));
        end
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic vector_fetch;
        begin_program(16'h8123);
        end_program();
        release_reset();
        @(negedge clk);
        check_addr(addr, 16'hfffc, "first cycle after reset");
        check_bit(we, 1'b0, "we in first cycle");
        @(negedge clk);
        check_addr(addr, 16'hfffd, "second cycle after reset");
        check_bit(we, 1'b0, "we in second cycle");
        @(negedge clk);
        check_addr(addr, 16'h8123, "first opcode fetch");
        check_bit(we, 1'b0, "we in third cycle");
        wait_sentinel(1'b0);
        compare_writes("vector fetch");
    endtask

    task automatic load_store(input bit stalls);
        begin_program(16'h0200);
        mem[16'h3000] = ls_val[3];
        mem[16'h3001] = ls_val[4];
        mem[16'h3002] = ls_val[5];
        put_op_byte(8'ha9, ls_val[0]);              // LDA #
        put_op_byte(8'h85, 8'h10);                  // STA zp
        put_op_byte(8'ha2, ls_val[1]);              // LDX #
        put_op_word(8'h8e, 16'h1234);               // STX abs
        put_op_byte(8'ha0, ls_val[2]);              // LDY #
        put_op_byte(8'h84, 8'h20);                  // STY zp
        put_op_word(8'had, 16'h3000);               // LDA abs
        put_op_word(8'h8d, 16'h1301);               // STA abs
        put_op_word(8'hae, 16'h3001);               // LDX abs
        put_op_byte(8'h86, 8'h30);                  // STX zp
        put_op_word(8'hac, 16'h3002);               // LDY abs
        put_op_word(8'h8c, 16'h1400);               // STY abs
        end_program();
        expect_write(16'h0010, ls_val[0]);
        expect_write(16'h1234, ls_val[1]);
        expect_write(16'h0020, ls_val[2]);
        expect_write(16'h1301, ls_val[3]);
        expect_write(16'h0030, ls_val[4]);
        expect_write(16'h1400, ls_val[5]);
        release_reset();
        wait_sentinel(stalls);
        compare_writes(stalls ? "stalled load/store" : "load/store");
    endtask

    task automatic alu_ops;
        int a, b, res;
        begin_program(16'h0200);
        for (int k = 0; k < 2; k++) begin
            a = $urandom % 256;
            b = $urandom % 256;
            res = 8'h40 + 8 * k;
            mem[16'h0050 + k] = byte_t'(b);
            mem[16'h3100 + k] = byte_t'(b);
            put(8'h18);                             // CLC
            lda_op_sta(a, 8'h09, b, res);           // ORA #
            lda_op_sta(a, 8'h25, 8'h50 + k, res + 1);
            lda_op_sta(a, 8'h4d, 16'h3100 + k, res + 2);
            put(8'h18);
            lda_op_sta(a, 8'h69, b, res + 3);       // ADC #, carry clear
            put(8'h38);                             // SEC
            lda_op_sta(a, 8'h65, 8'h50 + k, res + 4);
            put(8'h38);
            lda_op_sta(a, 8'hed, 16'h3100 + k, res + 5);
            put(8'h18);
            lda_op_sta(a, 8'he9, b, res + 6);       // SBC #, borrow in
            expect_write(res, a | b);
            expect_write(res + 1, a & b);
            expect_write(res + 2, a ^ b);
            expect_write(res + 3, a + b);
            expect_write(res + 4, a + b + 1);
            expect_write(res + 5, a - b);
            expect_write(res + 6, a - b - 1);
        end
        end_program();
        release_reset();
        wait_sentinel(1'b0);
        compare_writes("ALU");
    endtask

    task automatic compare_carry;
        int a, b;
        begin_program(16'h0200);
        for (int i = 0; i < 4; i++) begin
            a = $urandom % 256;
            b = (i == 0) ? a : $urandom % 256;      // Equal operands once
            mem[16'h0070 + i] = byte_t'(b);
            put_op_byte(8'ha9, a);
            if (i % 2 == 1)
                put_op_byte(8'hc5, 8'h70 + i);      // CMP zp
            else
                put_op_byte(8'hc9, b);              // CMP #
            put_op_byte(8'ha9, 0);
            put_op_byte(8'h69, 0);                  // A becomes the carry
            put_op_byte(8'h85, 8'h60 + i);
            expect_write(16'h0060 + i, (a >= b) ? 1 : 0);
        end
        end_program();
        release_reset();
        wait_sentinel(1'b0);
        compare_writes("compare");
    endtask

    task automatic transfers_jmp;
        int a, c, d;
        a = $urandom % 256;
        c = $urandom % 256;
        d = $urandom % 256;
        begin_program(16'h0200);
        put_op_byte(8'ha9, a);
        put(8'haa);                                 // TAX
        put(8'he8);                                 // INX
        put(8'h8a);                                 // TXA
        put_op_byte(8'h85, 8'h80);
        put_op_byte(8'ha0, c);
        put(8'h88);                                 // DEY
        put(8'h98);                                 // TYA
        put_op_byte(8'h85, 8'h81);
        put_op_byte(8'ha9, d);
        put(8'ha8);                                 // TAY
        put(8'hc8);                                 // INY
        put_op_byte(8'h84, 8'h82);
        put(8'hca);                                 // DEX
        put_op_byte(8'h86, 8'h83);
        put_op_word(8'h4c, 16'h0400);               // JMP to next page
        put_op_byte(8'h85, 8'h84);                  // Skipped
        load_ptr = 16'h0400;
        put_op_byte(8'h85, 8'h85);
        end_program();
        expect_write(16'h0080, a + 1);
        expect_write(16'h0081, c - 1);
        expect_write(16'h0082, d + 1);
        expect_write(16'h0083, a);
        expect_write(16'h0085, d);
        release_reset();
        wait_sentinel(1'b0);
        compare_writes("transfer/jump");
    endtask

    initial begin : main
        void'($urandom(32'h84bb_d37a));
        reset = 1'b1;
        rdy = 1'b1;
        errors = 0;
        for (int i = 0; i < 6; i++)
            ls_val[i] = byte_t'($urandom);
        vector_fetch();
        load_store(1'b0);
        alu_ops();
        compare_carry();
        transfers_jmp();
        load_store(1'b1);                           // Same writes expected under RDY stalls
        $display("Errors: %0d", errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: simulation ran past %0d cycles", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
common/cpu_pkg.sv
hdl/cpu_pc_addr.sv
hdl/cpu_alu.sv
hdl/cpu_regfile.sv
hdl/cpu_control.sv
hdl/cpu_core.sv
tests/tb_cpu.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -f all.f --top-module tb_cpu -o tb_cpu
./obj_dir/tb_cpu | tee sim.log
if grep -qx '>>> PASS' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
